// ==== occupancy_threshold.f ====
+incdir+source
source/occupancy_threshold_pkg.sv
source/occupancy_lo_counter.sv
source/occupancy_mid_counter.sv
source/occupancy_hi_counter.sv
source/threshold_crossing.sv
source/occupancy_threshold.sv
verification/occupancy_threshold_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the occupancy threshold testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=occupancy_threshold_sim
LOG_FILE=sim.log

verilator --binary --timing \
    -f occupancy_threshold.f \
    --top-module occupancy_threshold_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "run_sim: simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG_FILE"; then
    echo "run_sim: PASS"
    exit 0
fi

echo "run_sim: FAIL"
exit 1

// ==== source/occupancy_hi_counter.sv ====
//////////////////////////////////////////////////////////////////////
// bits 5 and up of the occupancy, reversed and split into stages
// each stage trails the one below it by one more edge and the zero
// detect adds one or two edges, so upper_zeros is up to 12 edges late
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module occupancy_hi_counter (
    input  logic                               clock,
    input  logic                               aclrn,
    input  occupancy_threshold_pkg::occ_mid_t  mid,
    input  logic                               mid_wrap,
    output logic                               upper_zeros
);

    import occupancy_threshold_pkg::*;

    // the zero detect covers the high bits plus bit two of mid, padded up
    // to whole groups of six so that every group fits one lookup table
    localparam int ZD_BITS = HI_BITS + 1;
    localparam int ZD_GROUPS = (ZD_BITS + 5) / 6;
    localparam int ZD_PAD = 6 * ZD_GROUPS;
    localparam logic [ZD_PAD-1:0] ZD_RESET = ZD_PAD'({HI_RESET, MID_RESET[2]});

    // all stage slices put together
    occ_hi_t hi;

    // index n is the wrap strobe and the low bit of the stage below stage n
    // and index 0 comes from the middle counter
    logic [TESS_STAGES-1:0] wrap;
    logic [TESS_STAGES-1:0] odd;

    logic [ZD_PAD-1:0] zd_bits;

    assign wrap[0] = mid_wrap;
    assign odd[0] = mid[0];

    //////////////////////////////////////////////////////////////////////
    // tessellated stages
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < TESS_STAGES; g++) begin : gen_stage
        // bounds of this slice, the bits are spread as evenly as possible
        localparam int LSB = g * HI_BITS / TESS_STAGES;
        localparam int MSB_EX = (g + 1) * HI_BITS / TESS_STAGES;
        localparam int W = MSB_EX - LSB;

        logic [W-1:0] slice;

        // an odd value below means that stage just went down through zero
        always_ff @(posedge clock or negedge aclrn) begin
            if (!aclrn) begin
                slice <= HI_RESET[MSB_EX-1:LSB];
            end else if (wrap[g]) begin
                if (odd[g]) begin
                    slice <= slice - W'(1);
                end else begin
                    slice <= slice + W'(1);
                end
            end
        end

        assign hi[MSB_EX-1:LSB] = slice;

        // the top stage has nobody above it to carry into
        if (g < TESS_STAGES - 1) begin : gen_carry
            logic slice_wrap;

            // registered from the next-state condition, so the strobe is
            // high in the same cycle the slice shows its wrapped value
            always_ff @(posedge clock or negedge aclrn) begin
                if (!aclrn) begin
                    slice_wrap <= 1'b0;
                end else begin
                    slice_wrap <= wrap[g] & (odd[g] ? (slice == '0) : (slice == '1));
                end
            end

            assign wrap[g+1] = slice_wrap;
            assign odd[g+1] = slice[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // zero detect over the high bits and bit two of mid
    //////////////////////////////////////////////////////////////////////

    assign zd_bits = ZD_PAD'({hi, mid[2]});

    if (ZD_GROUPS == 1) begin : gen_zd_one
        always_ff @(posedge clock or negedge aclrn) begin
            if (!aclrn) begin
                upper_zeros <= (ZD_RESET == '0);
            end else begin
                upper_zeros <= (zd_bits == '0);
            end
        end
    end else begin : gen_zd_two
        // first stage tests each group of six, second stage merges them
        logic [ZD_GROUPS-1:0] group_zero;

        always_ff @(posedge clock or negedge aclrn) begin
            if (!aclrn) begin
                for (int i = 0; i < ZD_GROUPS; i++) begin
                    group_zero[i] <= (ZD_RESET[6*i +: 6] == '0);
                end
                upper_zeros <= (ZD_RESET == '0);
            end else begin
                for (int i = 0; i < ZD_GROUPS; i++) begin
                    group_zero[i] <= (zd_bits[6*i +: 6] == '0);
                end
                upper_zeros <= &group_zero;
            end
        end
    end

endmodule

// ==== source/occupancy_lo_counter.sv ====
//////////////////////////////////////////////////////////////////////
// exact low two bits of the occupancy count
// incr and decr together cancel, the user keeps the count in range
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module occupancy_lo_counter (
    input  logic                              clock,
    input  logic                              aclrn,
    input  logic                              incr,
    input  logic                              decr,
    output occupancy_threshold_pkg::occ_lo_t  lo,
    output logic                              lo_wrap
);

    import occupancy_threshold_pkg::*;

    // net direction of this cycle, both strobes together are no change
    logic step_up;
    logic step_down;

    assign step_up = incr & ~decr;
    assign step_down = ~incr & decr;

    //////////////////////////////////////////////////////////////////////
    // low count and wrap strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            lo <= LO_RESET;
            lo_wrap <= 1'b0;
        end else begin
            // bit 0 toggles whenever exactly one strobe is present
            lo[0] <= lo[0] ^ incr ^ decr;
            // bit 1 takes the carry going up and the borrow going down
            lo[1] <= lo[1] ^ (step_up & lo[0]) ^ (step_down & ~lo[0]);

            // the wrap is taken from the next-state condition so that the
            // registered strobe is high in the cycle lo shows the wrapped value
            lo_wrap <= (step_up & (lo == 2'd3)) | (step_down & (lo == 2'd0));
        end
    end

endmodule

// ==== source/occupancy_mid_counter.sv ====
//////////////////////////////////////////////////////////////////////
// bits 4:2 of the occupancy, kept in reversed sense
// the value trails the real count by one edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module occupancy_mid_counter (
    input  logic                               clock,
    input  logic                               aclrn,
    input  occupancy_threshold_pkg::occ_lo_t   lo,
    input  logic                               lo_wrap,
    output occupancy_threshold_pkg::occ_mid_t  mid,
    output logic                               mid_wrap
);

    import occupancy_threshold_pkg::*;

    // while lo_wrap is high lo already holds its wrapped value
    // an odd lo means it went from 0 down to 3, so the occupancy dropped
    // and the reversed middle count has to step up
    logic step_up;
    logic step_down;

    assign step_up = lo_wrap & lo[0];
    assign step_down = lo_wrap & ~lo[0];

    //////////////////////////////////////////////////////////////////////
    // middle count and wrap strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            mid <= MID_RESET;
            mid_wrap <= 1'b0;
        end else begin
            if (step_up) begin
                mid <= mid + 3'd1;
            end else if (step_down) begin
                mid <= mid - 3'd1;
            end

            // the carry into the high bits sits between 5 and 6 because of
            // the offset of 5 in the reset value
            // like lo_wrap it is registered from the next-state condition
            mid_wrap <= (step_up & (mid == 3'd5)) | (step_down & (mid == 3'd6));
        end
    end

endmodule

// ==== source/occupancy_threshold.sv ====
//////////////////////////////////////////////////////////////////////
// occupancy threshold detector with one edge from strobe to output
// never incr at capacity and never decr at zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module occupancy_threshold (
    input  logic clock,
    input  logic aclrn,
    input  logic incr,
    input  logic decr,
    output logic threshold_reached
);

    import occupancy_threshold_pkg::*;

    // the three parts of the tessellated count and their carries
    occ_lo_t  lo;
    logic     lo_wrap;
    occ_mid_t mid;
    logic     mid_wrap;
    logic     upper_zeros;

    occupancy_lo_counter occupancy_lo_counter_i (
        .clock   (clock),
        .aclrn   (aclrn),
        .incr    (incr),
        .decr    (decr),
        .lo      (lo),
        .lo_wrap (lo_wrap)
    );

    occupancy_mid_counter occupancy_mid_counter_i (
        .clock    (clock),
        .aclrn    (aclrn),
        .lo       (lo),
        .lo_wrap  (lo_wrap),
        .mid      (mid),
        .mid_wrap (mid_wrap)
    );

    occupancy_hi_counter occupancy_hi_counter_i (
        .clock       (clock),
        .aclrn       (aclrn),
        .mid         (mid),
        .mid_wrap    (mid_wrap),
        .upper_zeros (upper_zeros)
    );

    threshold_crossing threshold_crossing_i (
        .clock             (clock),
        .aclrn             (aclrn),
        .incr              (incr),
        .decr              (decr),
        .lo                (lo),
        .lo_wrap           (lo_wrap),
        .mid               (mid),
        .upper_zeros       (upper_zeros),
        .threshold_reached (threshold_reached)
    );

endmodule

// ==== source/occupancy_threshold_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// build-time configuration of the occupancy threshold detector
// capacity must be above 32, threshold from 1 up to the capacity
// and the initial occupancy from 0 up to the capacity
//////////////////////////////////////////////////////////////////////

`ifndef OCCUPANCY_THRESHOLD_CFG_SVH
`define OCCUPANCY_THRESHOLD_CFG_SVH

// largest number of words the tracked FIFO can hold
`define OCC_CAPACITY 1024

// threshold_reached is high while the occupancy is at or above this value
`define OCC_THRESHOLD 300

// occupancy right after reset
`define OCC_INITIAL 0

// minimum number of high count bits in one tessellation stage
// smaller stages mean more wrap registers, larger ones mean longer carry logic
`define OCC_MIN_TESS_SIZE 4

`endif

// ==== source/occupancy_threshold_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// count-part types and reset values for the tessellated counter
// all values follow from the macros of the configuration header
//////////////////////////////////////////////////////////////////////

`include "occupancy_threshold_cfg.svh"

package occupancy_threshold_pkg;

    // bits 5 and up of the count, the lower five live in lo and mid
    localparam int HI_BITS = $clog2(`OCC_CAPACITY) - 5;

    // stage count before and after clipping, stage 8 is already 10 edges late
    localparam int TESS_RAW = (HI_BITS + `OCC_MIN_TESS_SIZE - 1) / `OCC_MIN_TESS_SIZE;
    localparam int TESS_STAGES = (TESS_RAW > 9) ? 9 : TESS_RAW;

    typedef logic [1:0] occ_lo_t;
    typedef logic [2:0] occ_mid_t;
    typedef logic [HI_BITS-1:0] occ_hi_t;
    typedef logic [$clog2(`OCC_CAPACITY + 1)-1:0] occupancy_t;

    // the counter tracks the distance to the threshold, so the reset value
    // is the point that many increments to the left of the target column
    localparam longint OCC_TO_THRESH = `OCC_THRESHOLD - `OCC_INITIAL;
    localparam logic [63:0] LO_BASE = 64'(2 - OCC_TO_THRESH);
    localparam logic [63:0] MID_BASE = 64'(5 + OCC_TO_THRESH);
    localparam logic [63:0] HI_BASE = 64'(13 + OCC_TO_THRESH);

    localparam occ_lo_t LO_RESET = LO_BASE[1:0];
    localparam occ_mid_t MID_RESET = MID_BASE[4:2];
    localparam occ_hi_t HI_RESET = HI_BASE[HI_BITS+4:5];

    // count_at_target as it would be computed from the reset values
    localparam logic AT_TARGET_RESET = (MID_RESET[1:0] == 2'd1) &&
                                       ({HI_RESET, MID_RESET[2]} == '0);

    localparam logic REACHED_RESET = (`OCC_INITIAL >= `OCC_THRESHOLD);

endpackage

// ==== source/threshold_crossing.sv ====
//////////////////////////////////////////////////////////////////////
// decides when threshold_reached may change and registers it
// a change is only allowed one step below or at the threshold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module threshold_crossing (
    input  logic                               clock,
    input  logic                               aclrn,
    input  logic                               incr,
    input  logic                               decr,
    input  occupancy_threshold_pkg::occ_lo_t   lo,
    input  logic                               lo_wrap,
    input  occupancy_threshold_pkg::occ_mid_t  mid,
    input  logic                               upper_zeros,
    output logic                               threshold_reached
);

    import occupancy_threshold_pkg::*;

    // high when everything above bit 1 sits at the target column
    logic count_at_target;

    // mid[1:0] as it will be after this edge
    // the target is 1, reached from 0 on a reversed step up or from 2 on a
    // reversed step down
    logic mid_next_at_one;

    assign mid_next_at_one = !lo_wrap ? (mid[1:0] == 2'd1) :
                             lo[0]    ? (mid[1:0] == 2'd0) :
                                        (mid[1:0] == 2'd2);

    //////////////////////////////////////////////////////////////////////
    // target test and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            count_at_target <= AT_TARGET_RESET;
        end else begin
            count_at_target <= mid_next_at_one & upper_zeros;
        end
    end

    // lo is exact, so lo of 1 is one below the threshold and lo of 2 is the
    // threshold itself once count_at_target confirms the upper bits
    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            threshold_reached <= REACHED_RESET;
        end else begin
            if (incr && !decr && (lo == 2'd1) && count_at_target) begin
                threshold_reached <= 1'b1;
            end
            if (!incr && decr && (lo == 2'd2) && count_at_target) begin
                threshold_reached <= 1'b0;
            end
        end
    end

endmodule

// ==== verification/occupancy_threshold_tb.sv ====
//////////////////////////////////////////////////////////////////////
// table-driven testbench for the occupancy threshold detector
// the table rows assume the default capacity 1024 and threshold 300
// strobes that would overflow or underflow are masked before driving
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "occupancy_threshold_cfg.svh"

module occupancy_threshold_tb;

    import occupancy_threshold_pkg::*;

    localparam int NUM_ROWS = 20;
    localparam int MARGIN_CYCLES = 64;
    localparam int CLOCK_PERIOD = 8;

    // stimulus modes of a table row
    localparam int MODE_FILL = 0;
    localparam int MODE_DRAIN = 1;
    localparam int MODE_BOTH = 2;
    localparam int MODE_HOVER = 3;
    localparam int MODE_RANDOM = 4;
    localparam int MODE_IDLE = 5;

    // end occupancy of a random row is not known in advance
    localparam int NO_CHECK = -1;

    localparam occupancy_t THRESH = occupancy_t'(`OCC_THRESHOLD);
    localparam occupancy_t CAPACITY = occupancy_t'(`OCC_CAPACITY);
    localparam occupancy_t START_OCC = occupancy_t'(`OCC_INITIAL);

    //////////////////////////////////////////////////////////////////////
    // stimulus table with one test per row
    //////////////////////////////////////////////////////////////////////

    // fill to just below the threshold, cross it, then hover and hold
    // on both sides, walk through the low-bit aliases 44 and 812, fill up
    // to capacity, drain to zero and finish with random walks
    int row_mode [NUM_ROWS] = '{
        MODE_FILL, MODE_FILL, MODE_HOVER, MODE_BOTH, MODE_DRAIN,
        MODE_BOTH, MODE_HOVER, MODE_DRAIN, MODE_FILL, MODE_FILL,
        MODE_FILL, MODE_DRAIN, MODE_DRAIN, MODE_FILL, MODE_RANDOM,
        MODE_DRAIN, MODE_RANDOM, MODE_FILL, MODE_RANDOM, MODE_IDLE
    };
    int row_cycles [NUM_ROWS] = '{
        299, 1, 20, 8, 1,
        8, 21, 256, 768, 212,
        4, 1024, 3, 290, 3000,
        1024, 2000, 1024, 1500, 4
    };
    int row_end [NUM_ROWS] = '{
        299, 300, 300, 300, 299,
        299, 300, 44, 812, 1024,
        1024, 0, 0, 290, NO_CHECK,
        0, NO_CHECK, 1024, NO_CHECK, NO_CHECK
    };

    logic clock;
    logic aclrn;
    logic incr;
    logic decr;
    logic threshold_reached;

    // occupancy after every strobe driven so far
    occupancy_t model_occ;
    // output expected after the edge that samples the last driven strobes
    logic expected_reached;
    logic [31:0] rng_state;

    int error_count;
    int row_errors;
    int tests_ok;
    int tests_bad;

    occupancy_threshold occupancy_threshold_i (
        .clock             (clock),
        .aclrn             (aclrn),
        .incr              (incr),
        .decr              (decr),
        .threshold_reached (threshold_reached)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            MODE_FILL:   return "fill";
            MODE_DRAIN:  return "drain";
            MODE_BOTH:   return "both";
            MODE_HOVER:  return "hover";
            MODE_RANDOM: return "random";
            default:     return "idle";
        endcase
    endfunction

    task automatic check_reached(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t: threshold_reached expected %b, got %b (occupancy %0d)",
                     $time, expected, actual, model_occ);
            error_count++;
            row_errors++;
        end
    endtask

    task automatic check_occupancy(input occupancy_t expected, input occupancy_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: model_occ expected %0d, got %0d",
                     $time, expected, actual);
            error_count++;
            row_errors++;
        end
    endtask

    // drives one cycle of strobes on the rising edge, then checks the
    // output produced by the strobes of the previous cycle
    task automatic run_cycle(input int mode);
        logic do_incr;
        logic do_decr;
        @(posedge clock);
        do_incr = 1'b0;
        do_decr = 1'b0;
        case (mode)
            MODE_FILL: do_incr = 1'b1;
            MODE_DRAIN: do_decr = 1'b1;
            MODE_BOTH: begin
                do_incr = 1'b1;
                do_decr = 1'b1;
            end
            // steps toward the threshold from either side, so around it
            // the strobes alternate on every cycle
            MODE_HOVER: begin
                do_incr = (model_occ < THRESH);
                do_decr = !do_incr;
            end
            MODE_RANDOM: begin
                rng_state = xorshift(rng_state);
                do_incr = rng_state[0];
                do_decr = rng_state[1];
            end
            default: ;
        endcase
        // the user never steps past capacity or below zero
        if (do_incr && !do_decr && (model_occ == CAPACITY)) begin
            do_incr = 1'b0;
        end
        if (do_decr && !do_incr && (model_occ == '0)) begin
            do_decr = 1'b0;
        end
        incr <= do_incr;
        decr <= do_decr;
        @(negedge clock);
        check_reached(expected_reached, threshold_reached);
        if (do_incr && !do_decr) begin
            model_occ = model_occ + occupancy_t'(1);
        end else if (do_decr && !do_incr) begin
            model_occ = model_occ - occupancy_t'(1);
        end
        expected_reached = (model_occ >= THRESH);
    endtask

    task automatic report_test(input string name, input int cycles);
        if (row_errors == 0) begin
            tests_ok++;
            $display("test %-7s %5d cycles, occupancy %4d, ok", name, cycles, model_occ);
        end else begin
            tests_bad++;
            $display("test %-7s %5d cycles, occupancy %4d, %0d errors",
                     name, cycles, model_occ, row_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        aclrn = 1'b0;
        incr = 1'b0;
        decr = 1'b0;
        rng_state = 32'h361ba161;
        model_occ = START_OCC;
        expected_reached = (START_OCC >= THRESH);
        error_count = 0;
        row_errors = 0;
        tests_ok = 0;
        tests_bad = 0;

        repeat (3) @(posedge clock);
        aclrn <= 1'b1;
        @(negedge clock);
        check_reached(expected_reached, threshold_reached);
        report_test("reset", 3);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errors = 0;
            repeat (row_cycles[r]) run_cycle(row_mode[r]);
            if (row_end[r] != NO_CHECK) begin
                check_occupancy(occupancy_t'(row_end[r]), model_occ);
            end
            report_test(mode_name(row_mode[r]), row_cycles[r]);
        end

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d checks wrong",
                 tests_ok + tests_bad, tests_ok, tests_bad, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run length is the table's cycle count plus reset and margin
    initial begin
        int total;
        total = MARGIN_CYCLES + 3;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += row_cycles[i];
        end
        #(total * CLOCK_PERIOD);
        $display("watchdog expired after %0d cycles before the table was done", total);
        $display("Some tests failed");
        $finish;
    end

endmodule
